// ==== hdl/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

`endif

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
	input  logic             clk,
	input  logic             rst_n,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic             wb_we,
	output logic [31:0]      wb_adr,
	input  logic             wb_ack,
	input  logic [31:0]      wb_dat_r,
	output logic             retire_valid,
	output rv_pkg::retire_t  retire
);

	logic            fetch_valid;
	logic [31:0]     fetch_pc;
	logic [31:0]     fetch_instr;
	logic            redirect;
	logic [31:0]     redirect_pc;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [31:0]     rs1_rdata;
	logic [31:0]     rs2_rdata;
	rv_pkg::dec_ex_t dec;
	rv_pkg::ex_wb_t  ex;
	rv_pkg::ex_wb_t  wb;

	// instruction fetch only reads
	assign wb_we = 1'b0;

	rv_fetch_stage u_fetch (.clk, .rst_n, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_r,
		.redirect, .redirect_pc, .fetch_valid, .fetch_pc, .fetch_instr);

	rv_decode_stage u_decode (.clk, .rst_n, .fetch_valid, .fetch_pc, .fetch_instr,
		.redirect, .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata, .dec);

	rv_execute_stage u_execute (.clk, .rst_n, .dec, .wb, .ex, .redirect, .redirect_pc);

	rv_regfile u_regfile (.clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata,
		.ex, .wb, .retire_valid, .retire);

endmodule

// ==== hdl/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             fetch_valid,
	input  logic [31:0]      fetch_pc,
	input  logic [31:0]      fetch_instr,
	input  logic             redirect,
	output logic [4:0]       rs1_addr,
	output logic [4:0]       rs2_addr,
	input  logic [31:0]      rs1_rdata,
	input  logic [31:0]      rs2_rdata,
	output rv_pkg::dec_ex_t  dec
);

	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [4:0]      rd;
	logic            alt;
	logic [31:0]     imm_i;
	logic [31:0]     imm_u;
	logic [31:0]     imm_b;
	logic [31:0]     imm_j;
	logic            legal;
	logic            writes;
	rv_pkg::dec_ex_t d;

	function automatic rv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic f7_alt);
		case (f3)
			3'b000:  alu_op_of = f7_alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  alu_op_of = rv_pkg::alu_sll;
			3'b010:  alu_op_of = rv_pkg::alu_slt;
			3'b011:  alu_op_of = rv_pkg::alu_sltu;
			3'b100:  alu_op_of = rv_pkg::alu_xor;
			3'b101:  alu_op_of = f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  alu_op_of = rv_pkg::alu_or;
			default: alu_op_of = rv_pkg::alu_and;
		endcase
	endfunction

	assign opcode = fetch_instr[6:0];
	assign funct3 = fetch_instr[14:12];
	assign rd = fetch_instr[11:7];
	assign rs1_addr = fetch_instr[19:15];
	assign rs2_addr = fetch_instr[24:20];

	// funct7 bit 5 picks sub/sra; for addi it is only an immediate bit
	assign alt = fetch_instr[30] & ((opcode == op_reg) | (funct3 == 3'b101));

	assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
	assign imm_u = {fetch_instr[31:12], 12'd0};
	assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
		fetch_instr[30:25], fetch_instr[11:8], 1'b0};
	assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
		fetch_instr[20], fetch_instr[30:21], 1'b0};

	always_comb begin
		d = '0;
		d.pc = fetch_pc;
		d.rs1_addr = rs1_addr;
		d.rs2_addr = rs2_addr;
		d.rs1_data = rs1_rdata;
		d.rs2_data = rs2_rdata;
		d.funct3 = funct3;
		d.alu_op = alu_op_of(funct3, alt);
		legal = 1'b1;
		writes = 1'b0;
		case (opcode)
			op_reg: begin
				writes = 1'b1;
			end
			op_imm: begin
				d.imm = imm_i;
				d.use_imm = 1'b1;
				writes = 1'b1;
			end
			op_lui: begin
				d.imm = imm_u;
				d.res_sel = rv_pkg::res_lui;
				writes = 1'b1;
			end
			op_auipc: begin
				d.imm = imm_u;
				d.res_sel = rv_pkg::res_pcimm;
				writes = 1'b1;
			end
			op_jal: begin
				d.imm = imm_j;
				d.br_kind = rv_pkg::br_jal;
				d.res_sel = rv_pkg::res_pc4;
				writes = 1'b1;
			end
			op_jalr: begin
				d.imm = imm_i;
				d.br_kind = rv_pkg::br_jalr;
				d.res_sel = rv_pkg::res_pc4;
				writes = 1'b1;
			end
			op_branch: begin
				d.imm = imm_b;
				d.br_kind = rv_pkg::br_branch;
			end
			// unknown opcode becomes a bubble
			default: legal = 1'b0;
		endcase
		d.rd_addr = writes ? rd : 5'd0;
		d.rd_we = writes & (rd != 5'd0);
		// younger word dies when execute redirects
		d.valid = fetch_valid & legal & ~redirect;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec <= '0;
		end else begin
			dec <= d;
		end
	end

endmodule

// ==== hdl/rv_execute_stage.sv ====
`timescale 1ns/1ps

module rv_execute_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::dec_ex_t  dec,
	input  rv_pkg::ex_wb_t   wb,
	output rv_pkg::ex_wb_t   ex,
	output logic             redirect,
	output logic [31:0]      redirect_pc
);

	// set the cycle after a redirect
	logic           purge;
	logic           live;
	logic [31:0]    op_a;
	logic [31:0]    rs2_val;
	logic [31:0]    op_b;
	logic           is_sub;
	logic [31:0]    sum;
	logic [31:0]    alu_res;
	logic           br_eq;
	logic           br_lt;
	logic           br_ltu;
	logic           br_taken;
	logic [31:0]    target_base;
	logic [31:0]    target;
	logic [31:0]    result;
	rv_pkg::ex_wb_t ex_next;

	// newest producer wins: own output, then writeback, then decode read
	function automatic logic [31:0] fwd(input logic [4:0] addr, input logic [31:0] dflt,
		input rv_pkg::ex_wb_t ex_q, input rv_pkg::ex_wb_t wb_q);
		if (ex_q.valid && ex_q.rd_we && (ex_q.rd_addr != 5'd0) && (ex_q.rd_addr == addr)) begin
			fwd = ex_q.rd_data;
		end else if (wb_q.valid && wb_q.rd_we && (wb_q.rd_addr != 5'd0)
			&& (wb_q.rd_addr == addr)) begin
			fwd = wb_q.rd_data;
		end else begin
			fwd = dflt;
		end
	endfunction

	assign live = dec.valid & ~purge;
	assign op_a = fwd(dec.rs1_addr, dec.rs1_data, ex, wb);
	assign rs2_val = fwd(dec.rs2_addr, dec.rs2_data, ex, wb);
	assign op_b = dec.use_imm ? dec.imm : rs2_val;

	// one adder for add and sub
	assign is_sub = (dec.alu_op == rv_pkg::alu_sub);
	assign sum = op_a + (op_b ^ {32{is_sub}}) + {31'd0, is_sub};

	always_comb begin
		case (dec.alu_op)
			rv_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
			rv_pkg::alu_slt:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			rv_pkg::alu_sltu: alu_res = {31'd0, op_a < op_b};
			rv_pkg::alu_xor:  alu_res = op_a ^ op_b;
			rv_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
			rv_pkg::alu_sra:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			rv_pkg::alu_or:   alu_res = op_a | op_b;
			rv_pkg::alu_and:  alu_res = op_a & op_b;
			default:          alu_res = sum;
		endcase
	end

	// branch compare always on the two registers
	assign br_eq = (op_a == rs2_val);
	assign br_lt = ($signed(op_a) < $signed(rs2_val));
	assign br_ltu = (op_a < rs2_val);

	always_comb begin
		case (dec.funct3)
			3'b000:  br_taken = br_eq;
			3'b001:  br_taken = ~br_eq;
			3'b100:  br_taken = br_lt;
			3'b101:  br_taken = ~br_lt;
			3'b110:  br_taken = br_ltu;
			3'b111:  br_taken = ~br_ltu;
			default: br_taken = 1'b0;
		endcase
	end

	// also serves auipc as pc+imm
	assign target_base = (dec.br_kind == rv_pkg::br_jalr) ? op_a : dec.pc;
	assign target = target_base + dec.imm;
	assign redirect_pc = {target[31:1], target[0] & (dec.br_kind != rv_pkg::br_jalr)};

	assign redirect = live & ((dec.br_kind == rv_pkg::br_jal) | (dec.br_kind == rv_pkg::br_jalr)
		| ((dec.br_kind == rv_pkg::br_branch) & br_taken));

	always_comb begin
		case (dec.res_sel)
			rv_pkg::res_lui:   result = dec.imm;
			rv_pkg::res_pc4:   result = dec.pc + 32'd4;
			rv_pkg::res_pcimm: result = target;
			default:           result = alu_res;
		endcase
		ex_next.valid = live;
		ex_next.pc = dec.pc;
		ex_next.rd_addr = dec.rd_addr;
		ex_next.rd_we = live & dec.rd_we;
		ex_next.rd_data = result;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex <= '0;
			purge <= 1'b0;
		end else begin
			ex <= ex_next;
			purge <= redirect;
		end
	end

endmodule

// ==== hdl/rv_fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_fetch_stage (
	input  logic        clk,
	input  logic        rst_n,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic [31:0] wb_adr,
	input  logic        wb_ack,
	input  logic [31:0] wb_dat_r,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	output logic        fetch_valid,
	output logic [31:0] fetch_pc,
	output logic [31:0] fetch_instr
);

	// address of the next word to request
	logic [31:0] pc;
	// open cycle belongs to the old path
	logic        discard;
	logic [31:0] start_adr;

	assign start_adr = redirect ? redirect_pc : (fetch_valid ? wb_adr + 32'd4 : pc);
	assign wb_stb = wb_cyc;

	// word handed to decode in the ack cycle itself
	assign fetch_valid = wb_cyc & wb_ack & ~discard;
	assign fetch_pc = wb_adr;
	assign fetch_instr = wb_dat_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_cyc <= 1'b0;
			wb_adr <= `RV_RESET_PC;
			pc <= `RV_RESET_PC;
			discard <= 1'b0;
		end else begin
			// one classic cycle per word, the next request starts at the ack edge
			if (!wb_cyc || wb_ack) begin
				wb_cyc <= 1'b1;
				wb_adr <= start_adr;
			end
			pc <= start_adr;
			// redirect mid-cycle: let the ack come, drop its data
			if (wb_cyc && wb_ack) begin
				discard <= 1'b0;
			end else if (wb_cyc && redirect) begin
				discard <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

	// alu operations, 4 bits
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// flow class of an instruction
	typedef enum logic [1:0] {
		br_none,
		br_branch,
		br_jal,
		br_jalr
	} br_kind_e;

	// source of the rd value
	typedef enum logic [1:0] {
		res_alu,
		res_lui,
		res_pc4,
		res_pcimm
	} res_sel_e;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rs1_addr;
		logic [4:0]  rs2_addr;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		logic        use_imm;
		alu_op_e     alu_op;
		br_kind_e    br_kind;
		// branch condition
		logic [2:0]  funct3;
		logic [4:0]  rd_addr;
		logic        rd_we;
		res_sel_e    res_sel;
	} dec_ex_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd_addr;
		logic        rd_we;
		logic [31:0] rd_data;
	} ex_wb_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd_addr;
		logic        rd_we;
		logic [31:0] rd_data;
	} retire_t;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [4:0]       rs1_addr,
	input  logic [4:0]       rs2_addr,
	output logic [31:0]      rs1_rdata,
	output logic [31:0]      rs2_rdata,
	input  rv_pkg::ex_wb_t   ex,
	output rv_pkg::ex_wb_t   wb,
	output logic             retire_valid,
	output rv_pkg::retire_t  retire
);

	logic [31:0] regs [`RV_REG_COUNT];
	logic        wr_en;

	// x0 reads zero, a same-cycle write is passed straight through
	function automatic logic [31:0] read_port(input logic [4:0] addr, input logic [31:0] stored,
		input logic wr, input rv_pkg::ex_wb_t wb_q);
		if (addr == 5'd0) begin
			read_port = 32'd0;
		end else if (wr && (wb_q.rd_addr == addr)) begin
			read_port = wb_q.rd_data;
		end else begin
			read_port = stored;
		end
	endfunction

	assign wr_en = wb.valid & wb.rd_we & (wb.rd_addr != 5'd0);
	assign rs1_rdata = read_port(rs1_addr, regs[rs1_addr], wr_en, wb);
	assign rs2_rdata = read_port(rs2_addr, regs[rs2_addr], wr_en, wb);

	// writeback stage register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb <= ex;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wb.rd_addr] <= wb.rd_data;
		end
	end

	assign retire_valid = wb.valid;
	assign retire = '{pc: wb.pc, rd_addr: wb.rd_addr, rd_we: wb.rd_we, rd_data: wb.rd_data};

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_fetch_stage.sv
hdl/rv_decode_stage.sv
hdl/rv_regfile.sv
hdl/rv_execute_stage.sv
hdl/rv_core_top.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

	// golden image layout, word addresses
	localparam int count_at = 'h40;
	localparam int rec_base = 'h41;
	localparam int max_records = 63;

	logic            clk;
	logic            rst_n;
	logic            wb_cyc;
	logic            wb_stb;
	logic            wb_we;
	logic [31:0]     wb_adr;
	logic            wb_ack;
	logic [31:0]     wb_dat_r;
	logic            retire_valid;
	rv_pkg::retire_t retire;

	logic [31:0] golden [0:255];
	integer      seed = 32'h42a8201b;
	int          errors = 0;
	int          retired = 0;
	int          exp_count = 0;
	int          cycles = 0;
	int          limit = 0;
	int          wait_left = 0;
	int          base = 0;
	bit          busy = 0;
	bit          done = 0;

	rv_core_top DUT (.clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_ack, .wb_dat_r,
		.retire_valid, .retire);

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// program words live in the low 64 words of the image
	function automatic logic [31:0] fetch_word(input logic [31:0] adr);
		if (adr[31:8] != 24'd0 || adr[1:0] != 2'd0) begin
			fetch_word = 32'd0;
		end else begin
			fetch_word = golden[adr[7:2]];
		end
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// wishbone memory, 0 to 3 wait states per fetch, requests may follow back to back
	always @(negedge clk) begin
		// an ack still high here was taken at the last rising edge
		if (wb_ack) begin
			busy = 1'b0;
		end
		if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = $random(seed) & 3;
				check_equal("wb_we", {31'd0, wb_we}, 32'd0);
				if (wb_adr[31:8] != 24'd0 || wb_adr[1:0] != 2'd0) begin
					errors++;
					$display("fetch from address %h lies outside the program image", wb_adr);
				end
			end
			if (wait_left == 0) begin
				wb_ack <= 1'b1;
				wb_dat_r <= fetch_word(wb_adr);
			end else begin
				wb_ack <= 1'b0;
				wait_left--;
			end
		end else begin
			wb_ack <= 1'b0;
		end
	end

	// retire checker, outputs sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && retire_valid && !done) begin
			base = rec_base + 3 * retired;
			check_equal($sformatf("record %0d pc", retired), retire.pc, golden[base]);
			check_equal($sformatf("record %0d rd_we", retired), {31'd0, retire.rd_we},
				{31'd0, golden[base + 1][5]});
			// rd and data only mean something when a register is written
			if (golden[base + 1][5]) begin
				check_equal($sformatf("record %0d rd", retired), {27'd0, retire.rd_addr},
					{27'd0, golden[base + 1][4:0]});
				check_equal($sformatf("record %0d rd_data", retired), retire.rd_data,
					golden[base + 2]);
			end
			retired++;
			if (retired == exp_count) begin
				done = 1'b1;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_r = 32'd0;
		$readmemh("verification/rv_golden.txt", golden);
		if ($isunknown(golden[count_at]) || golden[count_at] == 0
			|| golden[count_at] > max_records) begin
			errors++;
			$display("golden file gives no usable retire count");
		end else begin
			exp_count = golden[count_at];
			limit = exp_count * 8 + 200;
			repeat (10) @(negedge clk);
			rst_n = 1'b1;
			while (!done && cycles < limit) begin
				@(posedge clk);
				cycles++;
			end
			if (!done) begin
				errors++;
				$display("timeout after %0d cycles, only %0d of %0d retires seen",
					cycles, retired, exp_count);
			end
		end
		$display("errors: %0d, retires checked: %0d of %0d", errors, retired, exp_count);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/rv_golden.txt ====
// program words from address 0; at word 40 the retire count, then the records
// each record: pc, {rd_we, rd[4:0]}, rd data (data and rd only checked when rd_we is set)
@0
800000B7 FFB00113 00700193 00310233 402182B3 00319333 003123B3 00313433
003144B3 0030D533 4030D5B3 00316633 003176B3 00321713 FFC12793 FFC13813
FFF14893 0040D913 4040D993 0701EA13 0F017A93 00001B17 00318663 00100B93
00200B93 00319463 00314463 00300C13 00315463 00316463 00317463 00400C13
00C00CEF 00500C13 00600C13 011C8D67 00700C13 019D0DB3 00000000 0000006F
@40
00000020
00000000 00000021 80000000 00000004 00000022 FFFFFFFB
00000008 00000023 00000007 0000000C 00000024 00000002
00000010 00000025 0000000C 00000014 00000026 00000380
00000018 00000027 00000001 0000001C 00000028 00000000
00000020 00000029 FFFFFFFC 00000024 0000002A 01000000
00000028 0000002B FF000000 0000002C 0000002C FFFFFFFF
00000030 0000002D 00000003 00000034 0000002E 00000010
00000038 0000002F 00000001 0000003C 00000030 00000001
00000040 00000031 00000004 00000044 00000032 08000000
00000048 00000033 F8000000 0000004C 00000034 00000077
00000050 00000035 000000F0 00000054 00000036 00001054
00000058 00000000 00000000 00000064 00000000 00000000
00000068 00000000 00000000 00000070 00000000 00000000
00000074 00000000 00000000 00000078 00000000 00000000
00000080 00000039 00000084 0000008C 0000003A 00000090
00000094 0000003B 00000114 0000009C 00000000 00000000
